// File: files.f
verilog/fifo_geometry_pkg.sv
verilog/fifo_link_pkg.sv
verilog/ram_sdp.sv
verilog/ram_sdp_composite.sv
verilog/fifo_write_stage.sv
verilog/fifo_read_stage.sv
verilog/banked_fifo.sv
+incdir+tests
tests/banked_fifo_tb.sv

// File: tests/banked_fifo_tb_checks.svh
// ----------------------------------------------------------
// Stimulus table, reference queue and typed compare tasks
// Included in the testbench body after the package imports
// ----------------------------------------------------------

`ifndef BANKED_FIFO_TB_CHECKS_SVH
`define BANKED_FIFO_TB_CHECKS_SVH

// ----------------------------------------------------------
// Stimulus table

localparam logic [1:0] CREDIT_EVERY = 2'd0;
localparam logic [1:0] CREDIT_NTH   = 2'd1;
localparam logic [1:0] CREDIT_HOLD  = 2'd2;
localparam int         NUM_ROWS     = 8;

typedef struct packed {
    logic [7:0] burst;
    logic [1:0] credit_mode;
    logic [3:0] credit_period;
    logic       random_payload;
    logic [3:0] release_count;
    logic [3:0] expected_latency;   // zero when not checked
    logic       full_rate;
} row_t;

row_t table_rows [NUM_ROWS];

task automatic set_row(input int index, input int burst, input logic [1:0] mode,
                       input int period, input logic random_payload,
                       input int release_count, input int latency, input logic full_rate);
    row_t row;
    row.burst            = 8'(burst);
    row.credit_mode      = mode;
    row.credit_period    = 4'(period);
    row.random_payload   = random_payload;
    row.release_count    = 4'(release_count);
    row.expected_latency = 4'(latency);
    row.full_rate        = full_rate;
    table_rows[index]    = row;
endtask

task automatic load_table();
    // Single item into an empty buffer
    set_row(0, 1, CREDIT_EVERY, 1, 1'b0, 0, 2, 1'b0);
    // Two full passes cover all banks and the pointer wrap
    set_row(1, DEPTH, CREDIT_EVERY, 1, 1'b1, 0, 0, 1'b1);
    set_row(2, DEPTH, CREDIT_EVERY, 1, 1'b1, 0, 0, 1'b1);
    // Consumer holds credit, then returns three one at a time
    set_row(3, 12, CREDIT_HOLD, 1, 1'b0, 3, 0, 1'b0);
    // Every slot filled, using the credits of the first reads
    set_row(4, DEPTH + OUT_CREDITS, CREDIT_HOLD, 1, 1'b1, 1, 0, 1'b0);
    set_row(5, 20, CREDIT_NTH, 3, 1'b1, 0, 0, 1'b0);
    set_row(6, 40, CREDIT_EVERY, 1, 1'b0, 0, 0, 1'b1);
    set_row(7, 1, CREDIT_EVERY, 1, 1'b1, 0, 2, 1'b0);
endtask

function automatic int total_items();
    int sum;
    sum = 0;
    for (int i = 0; i < NUM_ROWS; i++) begin
        sum += int'(table_rows[i].burst);
    end
    return sum;
endfunction

// ----------------------------------------------------------
// Expected results

// Items pushed and not yet seen on pop, oldest first
fifo_item_t expected_items [$];

// Producer spends one credit per push and gets back one per read
function automatic int expected_held_credits(input row_t row);
    return DEPTH - int'(row.burst) + OUT_CREDITS;
endfunction

int item_mismatches  = 0;
int count_mismatches = 0;
int bit_mismatches   = 0;
int other_failures   = 0;

task automatic compare_item(input string name, input fifo_item_t actual,
                            input fifo_item_t expected);
    if (actual !== expected) begin
        item_mismatches++;
        $display("Mismatch %s: got %h expected %h at cycle %0d",
                 name, actual, expected, cycle_count);
    end
endtask

task automatic compare_count(input string name, input logic [COUNT_WIDTH-1:0] actual,
                             input logic [COUNT_WIDTH-1:0] expected);
    if (actual !== expected) begin
        count_mismatches++;
        $display("Mismatch %s: got %h expected %h at cycle %0d",
                 name, actual, expected, cycle_count);
    end
endtask

task automatic compare_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
        bit_mismatches++;
        $display("Mismatch %s: got %h expected %h at cycle %0d",
                 name, actual, expected, cycle_count);
    end
endtask

`endif

// File: tests/banked_fifo_tb.sv
// ----------------------------------------------------------
// Testbench for banked_fifo with default parameters
// Producer and consumer models follow the credit rules
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module banked_fifo_tb;

    import fifo_link_pkg::*;
    import fifo_geometry_pkg::*;

    localparam int DEPTH          = DEFAULT_DEPTH;
    localparam int OUT_CREDITS    = DEFAULT_OUT_CREDITS;
    localparam int RESET_CYCLES   = 10;
    // Longer than the push to pop and credit round trips
    localparam int SETTLE_CYCLES  = 6;
    localparam int TIMEOUT_MARGIN = 200;

    // Starts low so that no falling edge is seen at time zero
    logic  clock = 1'b0;
    logic  rst;
    push_t push;
    logic  push_credit;
    logic  pop_credit;
    pop_t  pop;

    int     cycle_count = 0;
    int     cycle_limit = 0;
    integer seed        = 49751;
    logic   check_idle;

    // Producer and consumer state
    int         prod_credits;
    int         to_push;
    int         owed;
    int         grant_budget;
    logic [1:0] credit_mode;
    int         credit_period;
    logic       random_payload;
    int         row_index;
    int         item_counter;

    // Per-row statistics
    int pushes_in_row;
    int pops_in_row;
    int credits_in_row;
    int first_push_cycle;
    int first_pop_cycle;
    int last_pop_cycle;

    `include "banked_fifo_tb_checks.svh"

    banked_fifo DUT (
        .clock       (clock),
        .rst         (rst),
        .push        (push),
        .push_credit (push_credit),
        .pop_credit  (pop_credit),
        .pop         (pop)
    );

    initial begin
        forever #10 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    // ----------------------------------------------------------
    // Output monitor, sampled mid-cycle

    always @(negedge clock) begin
        if (check_idle) begin
            compare_bit("pop.valid", pop.valid, 1'b0);
            compare_bit("push_credit", push_credit, 1'b0);
        end
        if (pop.valid === 1'b1) begin
            if (expected_items.size() == 0) begin
                other_failures++;
                $display("Item appeared on pop with nothing pushed at cycle %0d", cycle_count);
            end else begin
                compare_item("pop.item", pop.item, expected_items.pop_front());
            end
            if (pops_in_row == 0) begin
                first_pop_cycle = cycle_count;
            end
            last_pop_cycle = cycle_count;
            pops_in_row++;
            owed++;
        end
        if (push_credit === 1'b1) begin
            credits_in_row++;
            prod_credits++;
        end
    end

    // ----------------------------------------------------------
    // Drivers, one call per clock cycle

    task automatic step_cycle();
        fifo_item_t  item;
        logic [31:0] rand_word;
        logic        grant;
        @(posedge clock);
        #1;
        push = '0;
        if (to_push > 0 && prod_credits > 0) begin
            if (random_payload) begin
                rand_word = $random(seed);
                item      = rand_word[19:0];
            end else begin
                item.tag  = row_index[3:0];
                item.data = item_counter[15:0];
            end
            if (pushes_in_row == 0) begin
                first_push_cycle = cycle_count;
            end
            push.valid = 1'b1;
            push.item  = item;
            expected_items.push_back(item);
            item_counter++;
            pushes_in_row++;
            prod_credits--;
            to_push--;
        end
        case (credit_mode)
            CREDIT_EVERY: grant = 1'b1;
            CREDIT_NTH:   grant = (cycle_count % credit_period) == 0;
            default:      grant = grant_budget > 0;
        endcase
        pop_credit = 1'b0;
        if (grant && owed > 0) begin
            pop_credit = 1'b1;
            owed--;
            if (credit_mode == CREDIT_HOLD) begin
                grant_budget--;
            end
        end
    endtask

    task automatic run_row(input int index);
        row_t row;
        row            = table_rows[index];
        row_index      = index;
        to_push        = row.burst;
        random_payload = row.random_payload;
        credit_mode    = row.credit_mode;
        credit_period  = row.credit_period;
        grant_budget   = 0;
        pushes_in_row  = 0;
        pops_in_row    = 0;
        credits_in_row = 0;
        while (to_push > 0) begin
            step_cycle();
        end
        if (row.credit_mode == CREDIT_HOLD) begin
            repeat (SETTLE_CYCLES) step_cycle();
            compare_count("pop items while held", pops_in_row, OUT_CREDITS);
            compare_count("producer credits while held", prod_credits,
                          expected_held_credits(row));
            grant_budget = row.release_count;
            while (grant_budget > 0) begin
                step_cycle();
            end
            repeat (SETTLE_CYCLES) step_cycle();
            compare_count("pop items after release", pops_in_row,
                          OUT_CREDITS + row.release_count);
            credit_mode = CREDIT_EVERY;
        end
        while (expected_items.size() > 0 || owed > 0) begin
            step_cycle();
        end
        step_cycle();
        compare_count("push_credit pulses", credits_in_row, pops_in_row);
        compare_count("pop items", pops_in_row, row.burst);
        compare_count("producer credits", prod_credits, DEPTH);
        if (row.expected_latency != 0) begin
            compare_count("push to pop latency", first_pop_cycle - first_push_cycle,
                          row.expected_latency);
        end
        if (row.full_rate) begin
            compare_count("pop span", last_pop_cycle - first_pop_cycle, row.burst - 1);
        end
    endtask

    // ----------------------------------------------------------
    // Main sequence

    initial begin
        rst          = 1'b1;
        push         = '0;
        pop_credit   = 1'b0;
        check_idle   = 1'b1;
        prod_credits = DEPTH;
        to_push      = 0;
        owed         = 0;
        grant_budget = 0;
        credit_mode  = CREDIT_EVERY;
        item_counter = 0;
        pops_in_row  = 0;
        load_table();
        cycle_limit = 4 * total_items() + RESET_CYCLES + TIMEOUT_MARGIN;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        rst = 1'b0;
        @(posedge clock);
        #1;
        check_idle = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        $display("Errors: %0d item, %0d count, %0d bit, %0d other",
                 item_mismatches, count_mismatches, bit_mismatches, other_failures);
        if (item_mismatches + count_mismatches + bit_mismatches + other_failures == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        wait (cycle_limit != 0 && cycle_count > cycle_limit);
        $display("Run did not complete within %0d cycles", cycle_limit);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/banked_fifo.sv
// ----------------------------------------------------------
// Banked FIFO with credit flow control on both links
// Producer starts with DEPTH credits, item out two cycles after push
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module banked_fifo #(
    parameter int DEPTH       = fifo_geometry_pkg::DEFAULT_DEPTH,
    parameter int BANK_DEPTH  = fifo_geometry_pkg::DEFAULT_BANK_DEPTH,
    parameter int OUT_CREDITS = fifo_geometry_pkg::DEFAULT_OUT_CREDITS
) (
    input  wire logic                 clock,
    input  wire logic                 rst,
    input  wire fifo_link_pkg::push_t push,
    output logic                      push_credit,
    input  wire logic                 pop_credit,
    output fifo_link_pkg::pop_t       pop
);

    import fifo_link_pkg::*;

    localparam int ADDR_WIDTH = $clog2(DEPTH);

    // RAM write port
    logic                  wren;
    logic [ADDR_WIDTH-1:0] write_addr;
    fifo_item_t            write_data;
    logic                  commit;

    // RAM read port
    logic                  rden;
    logic [ADDR_WIDTH-1:0] read_addr;
    fifo_item_t            read_data;

    fifo_write_stage #(
        .DEPTH       (DEPTH)
    ) u_write_stage (
        .clock       (clock),
        .rst         (rst),
        .push        (push),
        .wren        (wren),
        .write_addr  (write_addr),
        .write_data  (write_data),
        .commit      (commit)
    );

    ram_sdp_composite #(
        .word_t      (fifo_item_t),
        .DEPTH       (DEPTH),
        .BANK_DEPTH  (BANK_DEPTH)
    ) u_ram (
        .clock       (clock),
        .wren        (wren),
        .write_addr  (write_addr),
        .write_data  (write_data),
        .rden        (rden),
        .read_addr   (read_addr),
        .read_data   (read_data)
    );

    fifo_read_stage #(
        .DEPTH       (DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_read_stage (
        .clock       (clock),
        .rst         (rst),
        .commit      (commit),
        .pop_credit  (pop_credit),
        .rden        (rden),
        .read_addr   (read_addr),
        .read_data   (read_data),
        .pop         (pop),
        .push_credit (push_credit)
    );

endmodule

`default_nettype wire

// File: verilog/fifo_geometry_pkg.sv
// ----------------------------------------------------------
// Default buffer geometry and counter widths
// Depths are powers of two and the depth holds at least two banks
// ----------------------------------------------------------

`default_nettype none

package fifo_geometry_pkg;

    // ----------------------------------------------------------
    // Storage geometry

    // Total entries across all banks
    localparam int DEFAULT_DEPTH = 64;

    // Entries held by one bank
    localparam int DEFAULT_BANK_DEPTH = 16;

    // ----------------------------------------------------------
    // Flow control

    // Credits granted by the consumer at reset
    localparam int DEFAULT_OUT_CREDITS = 4;

    // Occupancy and credit counters, enough for depths up to 128
    localparam int COUNT_WIDTH = 8;

endpackage

`default_nettype wire

// File: verilog/fifo_link_pkg.sv
// ----------------------------------------------------------
// Payload and link structs for the producer and consumer side
// Both links carry a valid bit in front of one item
// ----------------------------------------------------------

`default_nettype none

package fifo_link_pkg;

    localparam int TAG_WIDTH  = 4;
    localparam int DATA_WIDTH = 16;

    // Stored word, tag in the upper bits
    typedef struct packed {
        logic [TAG_WIDTH-1:0]  tag;
        logic [DATA_WIDTH-1:0] data;
    } fifo_item_t;

    // Producer to buffer, one credit spent per valid cycle
    typedef struct packed {
        logic       valid;
        fifo_item_t item;
    } push_t;

    // Buffer to consumer, no stall once valid is seen
    typedef struct packed {
        logic       valid;
        fifo_item_t item;
    } pop_t;

endpackage

`default_nettype wire

// File: verilog/fifo_read_stage.sv
// ----------------------------------------------------------
// Read side, tracks occupancy and consumer credits
// Issues one read per cycle, item valid one cycle after issue
// Consumer takes every valid item, no stall on pop
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module fifo_read_stage #(
    parameter int      DEPTH       = fifo_geometry_pkg::DEFAULT_DEPTH,
    parameter int      OUT_CREDITS = fifo_geometry_pkg::DEFAULT_OUT_CREDITS,
    localparam int     ADDR_WIDTH  = $clog2(DEPTH)
) (
    input  wire logic                      clock,
    input  wire logic                      rst,
    input  wire logic                      commit,
    input  wire logic                      pop_credit,
    output logic                           rden,
    output logic [ADDR_WIDTH-1:0]          read_addr,
    input  wire fifo_link_pkg::fifo_item_t read_data,
    output fifo_link_pkg::pop_t            pop,
    output logic                           push_credit
);

    import fifo_geometry_pkg::*;

    logic [ADDR_WIDTH-1:0]  read_ptr;
    logic [COUNT_WIDTH-1:0] occupancy;
    logic [COUNT_WIDTH-1:0] occupancy_next;
    logic [COUNT_WIDTH-1:0] credits;
    logic [COUNT_WIDTH-1:0] credits_next;

    // Matches the one cycle RAM read latency
    logic                   read_valid_q;

    // ----------------------------------------------------------
    // Read issue

    // Both counters already account for reads in flight
    assign rden      = (occupancy != '0) && (credits != '0);
    assign read_addr = read_ptr;

    // ----------------------------------------------------------
    // Counter updates

    // Commit and read in the same cycle leave occupancy unchanged
    always_comb begin
        occupancy_next = occupancy;
        if (commit && !rden) begin
            occupancy_next = occupancy + 1'b1;
        end else if (!commit && rden) begin
            occupancy_next = occupancy - 1'b1;
        end
    end

    // Credit is spent at read issue, not when the item leaves
    always_comb begin
        credits_next = credits;
        if (pop_credit && !rden) begin
            credits_next = credits + 1'b1;
        end else if (!pop_credit && rden) begin
            credits_next = credits - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            read_ptr     <= '0;
            occupancy    <= '0;
            credits      <= COUNT_WIDTH'(OUT_CREDITS);
            read_valid_q <= 1'b0;
        end else begin
            if (rden) begin
                if (read_ptr == ADDR_WIDTH'(DEPTH - 1)) begin
                    read_ptr <= '0;
                end else begin
                    read_ptr <= read_ptr + 1'b1;
                end
            end
            occupancy    <= occupancy_next;
            credits      <= credits_next;
            read_valid_q <= rden;
        end
    end

    // ----------------------------------------------------------
    // Output link and credit return

    assign pop = '{valid: read_valid_q, item: read_data};

    // Slot is free once its item has been read out
    assign push_credit = read_valid_q;

endmodule

`default_nettype wire

// File: verilog/fifo_write_stage.sv
// ----------------------------------------------------------
// Write side of the buffer, one item stored per valid push
// Producer must hold a credit, overflow is not detected
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module fifo_write_stage #(
    parameter int      DEPTH      = fifo_geometry_pkg::DEFAULT_DEPTH,
    localparam int     ADDR_WIDTH = $clog2(DEPTH)
) (
    input  wire logic                      clock,
    input  wire logic                      rst,
    input  wire fifo_link_pkg::push_t      push,
    output logic                           wren,
    output logic [ADDR_WIDTH-1:0]          write_addr,
    output fifo_link_pkg::fifo_item_t      write_data,
    output logic                           commit
);

    // ----------------------------------------------------------
    // Write pointer

    logic [ADDR_WIDTH-1:0] write_ptr;
    logic [ADDR_WIDTH-1:0] write_ptr_next;

    // Wrap at the last entry
    always_comb begin
        if (write_ptr == ADDR_WIDTH'(DEPTH - 1)) begin
            write_ptr_next = '0;
        end else begin
            write_ptr_next = write_ptr + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            write_ptr <= '0;
        end else if (push.valid) begin
            write_ptr <= write_ptr_next;
        end
    end

    // ----------------------------------------------------------
    // RAM write port

    // Item goes straight to the RAM in the cycle it arrives
    assign wren       = push.valid;
    assign write_addr = write_ptr;
    assign write_data = push.item;

    // ----------------------------------------------------------
    // Commit to the read stage

    // The RAM stores the item at the same edge, so the read side
    // may count it as soon as it sees commit
    assign commit = push.valid;

endmodule

`default_nettype wire

// File: verilog/ram_sdp.sv
// ----------------------------------------------------------
// Simple dual-port RAM bank with a registered read
// A read of the address written in the same cycle returns old data
// DEPTH must be a power of two
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module ram_sdp #(
    parameter type     word_t     = logic [15:0],
    parameter int      DEPTH      = 16,
    localparam int     ADDR_WIDTH = $clog2(DEPTH)
) (
    input  wire logic                  clock,
    input  wire logic                  wren,
    input  wire logic [ADDR_WIDTH-1:0] write_addr,
    input  wire word_t                 write_data,
    input  wire logic                  rden,
    input  wire logic [ADDR_WIDTH-1:0] read_addr,
    output word_t                      read_data
);

    // ----------------------------------------------------------
    // Storage array

    word_t mem [DEPTH];

    // ----------------------------------------------------------
    // Write and read ports

    always_ff @(posedge clock) begin
        if (wren) begin
            mem[write_addr] <= write_data;
        end
    end

    // Output holds its value while rden is low
    always_ff @(posedge clock) begin
        if (rden) begin
            read_data <= mem[read_addr];
        end
    end

endmodule

`default_nettype wire

// File: verilog/ram_sdp_composite.sv
// ----------------------------------------------------------
// Simple dual-port RAM built from DEPTH/BANK_DEPTH banks
// Upper address bits pick a bank, one cycle read latency
// Both depths are powers of two with DEPTH > BANK_DEPTH
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module ram_sdp_composite #(
    parameter type     word_t     = logic [15:0],
    parameter int      DEPTH      = 64,
    parameter int      BANK_DEPTH = 16,
    localparam int     ADDR_WIDTH = $clog2(DEPTH)
) (
    input  wire logic                  clock,
    input  wire logic                  wren,
    input  wire logic [ADDR_WIDTH-1:0] write_addr,
    input  wire word_t                 write_data,
    input  wire logic                  rden,
    input  wire logic [ADDR_WIDTH-1:0] read_addr,
    output word_t                      read_data
);

    // ----------------------------------------------------------
    // Bank arrangement

    localparam int BANK_COUNT   = DEPTH / BANK_DEPTH;
    localparam int OFFSET_WIDTH = $clog2(BANK_DEPTH);
    localparam int SEL_WIDTH    = ADDR_WIDTH - OFFSET_WIDTH;

    logic [SEL_WIDTH-1:0]    write_sel;
    logic [OFFSET_WIDTH-1:0] write_offset;
    logic [SEL_WIDTH-1:0]    read_sel;
    logic [OFFSET_WIDTH-1:0] read_offset;

    // Select of the last bank read, drives the output mux
    logic [SEL_WIDTH-1:0]    read_sel_q;

    logic [BANK_COUNT-1:0]   bank_wren;
    logic [BANK_COUNT-1:0]   bank_rden;
    word_t                   bank_read_data [BANK_COUNT];

    // ----------------------------------------------------------
    // Address split

    assign write_sel    = write_addr[ADDR_WIDTH-1:OFFSET_WIDTH];
    assign write_offset = write_addr[OFFSET_WIDTH-1:0];
    assign read_sel     = read_addr[ADDR_WIDTH-1:OFFSET_WIDTH];
    assign read_offset  = read_addr[OFFSET_WIDTH-1:0];

    // ----------------------------------------------------------
    // Per-bank enables and bank instances

    generate
        for (genvar i = 0; i < BANK_COUNT; i++) begin : g_bank

            // Only the addressed bank sees an enable
            assign bank_wren[i] = wren && (write_sel == SEL_WIDTH'(i));
            assign bank_rden[i] = rden && (read_sel == SEL_WIDTH'(i));

            ram_sdp #(
                .word_t     (word_t),
                .DEPTH      (BANK_DEPTH)
            ) u_bank (
                .clock      (clock),
                .wren       (bank_wren[i]),
                .write_addr (write_offset),
                .write_data (write_data),
                .rden       (bank_rden[i]),
                .read_addr  (read_offset),
                .read_data  (bank_read_data[i])
            );

        end
    endgenerate

    // ----------------------------------------------------------
    // Registered read select and output mux

    // Captured with the read so the mux lines up with bank data
    // and keeps pointing at it while no read is issued
    always_ff @(posedge clock) begin
        if (rden) begin
            read_sel_q <= read_sel;
        end
    end

    assign read_data = bank_read_data[read_sel_q];

endmodule

`default_nettype wire
